/* common/exe_pkg.sv */
package exe_pkg;

    // Datapath and register file widths
    localparam int XLEN         = 32;
    localparam int RF_AWIDTH    = 5;
    localparam int SHAMT_WIDTH  = 5;
    localparam int CSR_AWIDTH   = 12;

    // Instruction field positions (LSB of each field)
    localparam int RD_LSB       = 7;
    localparam int RS1_LSB      = 15;
    localparam int RS2_LSB      = 20;
    localparam int CSR_ADDR_LSB = 20;

    // Plain vector types
    typedef logic [XLEN-1:0]        xlen_t;
    typedef logic [RF_AWIDTH-1:0]   rf_addr_t;
    typedef logic [SHAMT_WIDTH-1:0] shamt_t;
    typedef logic [CSR_AWIDTH-1:0]  csr_addr_t;
    typedef logic [31:0]            instr_t;

    // Integer ALU operations
    typedef enum logic [3:0] {
        ALU_OP_NONE      = 4'd0,
        ALU_OP_ADD       = 4'd1,
        ALU_OP_SUB       = 4'd2,
        ALU_OP_AND       = 4'd3,
        ALU_OP_OR        = 4'd4,
        ALU_OP_XOR       = 4'd5,
        ALU_OP_SLL       = 4'd6,
        ALU_OP_SRL       = 4'd7,
        ALU_OP_SRA       = 4'd8,
        ALU_OP_SLT       = 4'd9,
        ALU_OP_SLTU      = 4'd10,
        ALU_OP_COPY_OPR1 = 4'd11,
        ALU_OP_COPY_OPR2 = 4'd12
    } alu_op_e;

    // Branch conditions
    typedef enum logic [2:0] {
        BR_OP_NONE = 3'd0,
        BR_OP_EQ   = 3'd1,
        BR_OP_NE   = 3'd2,
        BR_OP_LT   = 3'd3,
        BR_OP_LTU  = 3'd4,
        BR_OP_GE   = 3'd5,
        BR_OP_GEU  = 3'd6
    } br_op_e;

    // CSR access kinds
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'd0,
        CSR_OP_WRITE = 2'd1,
        CSR_OP_SET   = 2'd2,
        CSR_OP_CLEAR = 2'd3
    } csr_op_e;

    // Operand source selects
    typedef enum logic {OPR1_SEL_REG, OPR1_SEL_PC} opr1_sel_e;
    typedef enum logic {OPR2_SEL_REG, OPR2_SEL_IMM} opr2_sel_e;
    typedef enum logic {CMP_OPR2_SEL_REG, CMP_OPR2_SEL_IMM} cmp_opr2_sel_e;
    typedef enum logic {CSR_OPR_SEL_REG, CSR_OPR_SEL_IMM} csr_opr_sel_e;

    // Decode to execute control
    typedef struct packed {
        alu_op_e       alu_op;
        br_op_e        br_op;
        csr_op_e       csr_op;
        opr1_sel_e     opr1_sel;
        opr2_sel_e     opr2_sel;
        cmp_opr2_sel_e cmp_opr2_sel;
        csr_opr_sel_e  csr_opr_sel;
        logic          jump_req;
        logic          branch_req;
        logic          fence_i_req;
        logic          rd_wr_req;
    } id2exe_ctrl_s;

    // Decode to execute data
    typedef struct packed {
        instr_t instr;
        xlen_t  pc;
        xlen_t  pc_next;
        xlen_t  imm;
        xlen_t  rs1_data;
        xlen_t  rs2_data;
    } id2exe_data_s;

    // Forwarding selects from the hazard unit
    typedef struct packed {
        logic fwd_lsu_rs1;
        logic fwd_wrb_rs1;
        logic fwd_lsu_rs2;
        logic fwd_wrb_rs2;
    } fwd_sel_s;

    // Comparator flags
    typedef struct packed {
        logic not_zero;
        logic neg;
        logic overflow;
        logic carry;
    } cmp_flags_s;

    // Execute to LSU bundle
    typedef struct packed {
        xlen_t    alu_result;
        xlen_t    rs2_data;
        rf_addr_t rd_addr;
        logic     rd_wr_req;
    } exe2lsu_s;

    // Execute to CSR bundle
    typedef struct packed {
        csr_addr_t csr_addr;
        xlen_t     csr_wdata;
        csr_op_e   csr_op;
        logic      csr_rd_req;
        logic      csr_wr_req;
    } exe2csr_s;

    // Fetch redirect
    typedef struct packed {
        logic  new_pc_req;
        xlen_t pc_new;
    } redirect_s;

endpackage : exe_pkg

/* hdl/operand_fwd.sv */
`timescale 1ns/10ps

module operand_fwd
    import exe_pkg::*;
(
    input  id2exe_ctrl_s id2exe_ctrl_i,
    input  id2exe_data_s id2exe_data_i,
    input  fwd_sel_s     fwd_sel_i,
    input  xlen_t        lsu_fb_data_i,
    input  xlen_t        wrb_fb_data_i,
    output xlen_t        rs1_fwd_o,
    output xlen_t        rs2_fwd_o,
    output xlen_t        alu_opr1_o,
    output xlen_t        alu_opr2_o,
    output xlen_t        cmp_opr2_o
);

    // Forwarded source operands
    xlen_t rs1_fwd;
    xlen_t rs2_fwd;

    // rs1 source, LSU result is the youngest so it has priority
    always_comb begin
        if (fwd_sel_i.fwd_lsu_rs1) begin
            rs1_fwd = lsu_fb_data_i;
        end else if (fwd_sel_i.fwd_wrb_rs1) begin
            rs1_fwd = wrb_fb_data_i;
        end else begin
            rs1_fwd = id2exe_data_i.rs1_data;
        end
    end

    // rs2 source, same priority order
    always_comb begin
        if (fwd_sel_i.fwd_lsu_rs2) begin
            rs2_fwd = lsu_fb_data_i;
        end else if (fwd_sel_i.fwd_wrb_rs2) begin
            rs2_fwd = wrb_fb_data_i;
        end else begin
            rs2_fwd = id2exe_data_i.rs2_data;
        end
    end

    // ALU operand 1 is PC for auipc, jal and branch targets
    assign alu_opr1_o = (id2exe_ctrl_i.opr1_sel == OPR1_SEL_PC) ? id2exe_data_i.pc : rs1_fwd;

    // ALU operand 2 is the immediate for I/U/J types
    assign alu_opr2_o = (id2exe_ctrl_i.opr2_sel == OPR2_SEL_IMM) ? id2exe_data_i.imm : rs2_fwd;

    // Comparator operand 2, immediate for slti/sltiu
    assign cmp_opr2_o = (id2exe_ctrl_i.cmp_opr2_sel == CMP_OPR2_SEL_IMM)
                      ? id2exe_data_i.imm
                      : rs2_fwd;

    // Store data and CSR data need the forwarded values too
    assign rs1_fwd_o = rs1_fwd;
    assign rs2_fwd_o = rs2_fwd;

endmodule : operand_fwd

/* alu/branch_cmp.sv */
`timescale 1ns/10ps

module branch_cmp
    import exe_pkg::*;
(
    input  xlen_t      rs1_fwd_i,
    input  xlen_t      cmp_opr2_i,
    input  br_op_e     br_op_i,
    output cmp_flags_s cmp_flags_o,
    output logic       branch_taken_o
);

    // Difference with one extra bit for the borrow
    logic [XLEN:0] cmp_diff;
    cmp_flags_s    flags;
    logic          signed_lt;

    // Zero-extend both operands so the top bit is the borrow out
    assign cmp_diff = {1'b0, rs1_fwd_i} - {1'b0, cmp_opr2_i};

    assign flags.not_zero = |cmp_diff[XLEN-1:0];
    assign flags.neg      = cmp_diff[XLEN-1];
    // Borrow set means rs1 is below operand 2 as unsigned
    assign flags.carry    = cmp_diff[XLEN];

    // Signed overflow when operands differ in sign and result sign is wrong
    assign flags.overflow = (flags.neg & ~rs1_fwd_i[XLEN-1] & cmp_opr2_i[XLEN-1]) |
                            (~flags.neg & rs1_fwd_i[XLEN-1] & ~cmp_opr2_i[XLEN-1]);

    // Signed less-than
    assign signed_lt = flags.neg ^ flags.overflow;

    // Branch decision from the flags
    always_comb begin
        case (br_op_i)
            BR_OP_EQ: begin
                branch_taken_o = ~flags.not_zero;
            end
            BR_OP_NE: begin
                branch_taken_o = flags.not_zero;
            end
            BR_OP_LT: begin
                branch_taken_o = signed_lt;
            end
            BR_OP_LTU: begin
                branch_taken_o = flags.carry;
            end
            BR_OP_GE: begin
                branch_taken_o = ~signed_lt;
            end
            BR_OP_GEU: begin
                branch_taken_o = ~flags.carry;
            end
            default: begin
                // No branch or unused encoding
                branch_taken_o = 1'b0;
            end
        endcase
    end

    // Flags are shared with slt and sltu in the ALU
    assign cmp_flags_o = flags;

endmodule : branch_cmp

/* alu/int_alu.sv */
`timescale 1ns/10ps

module int_alu
    import exe_pkg::*;
(
    input  alu_op_e    alu_op_i,
    input  xlen_t      alu_opr1_i,
    input  xlen_t      alu_opr2_i,
    input  cmp_flags_s cmp_flags_i,
    output xlen_t      alu_result_o
);

    xlen_t  adder_out;
    shamt_t shamt;

    // Single adder, subtract for everything except add
    assign adder_out = (alu_op_i == ALU_OP_ADD)
                     ? (alu_opr1_i + alu_opr2_i)
                     : (alu_opr1_i - alu_opr2_i);

    // Shift amount from the low bits of operand 2
    assign shamt = alu_opr2_i[SHAMT_WIDTH-1:0];

    // Result select
    always_comb begin
        case (alu_op_i)
            ALU_OP_ADD,
            ALU_OP_SUB: begin
                alu_result_o = adder_out;
            end
            ALU_OP_AND: begin
                alu_result_o = alu_opr1_i & alu_opr2_i;
            end
            ALU_OP_OR: begin
                alu_result_o = alu_opr1_i | alu_opr2_i;
            end
            ALU_OP_XOR: begin
                alu_result_o = alu_opr1_i ^ alu_opr2_i;
            end
            ALU_OP_SLL: begin
                alu_result_o = alu_opr1_i << shamt;
            end
            ALU_OP_SRL: begin
                alu_result_o = alu_opr1_i >> shamt;
            end
            ALU_OP_SRA: begin
                // Sign bit fills from the left
                alu_result_o = xlen_t'($signed(alu_opr1_i) >>> shamt);
            end
            ALU_OP_SLT: begin
                alu_result_o = xlen_t'(cmp_flags_i.neg ^ cmp_flags_i.overflow);
            end
            ALU_OP_SLTU: begin
                alu_result_o = xlen_t'(cmp_flags_i.carry);
            end
            // Jump return address and PC copy
            ALU_OP_COPY_OPR1: begin
                alu_result_o = alu_opr1_i;
            end
            // lui passes the immediate
            ALU_OP_COPY_OPR2: begin
                alu_result_o = alu_opr2_i;
            end
            default: begin
                alu_result_o = '0;
            end
        endcase
    end

endmodule : int_alu

/* hdl/csr_req_gen.sv */
`timescale 1ns/10ps

module csr_req_gen
    import exe_pkg::*;
(
    input  id2exe_ctrl_s id2exe_ctrl_i,
    input  instr_t       instr_i,
    input  xlen_t        rs1_fwd_i,
    output exe2csr_s     exe2csr_o,
    output logic         rd_wr_req_o
);

    rf_addr_t rd_field;
    rf_addr_t rs1_field;
    exe2csr_s csr_req;

    // Register fields of the CSR instruction
    assign rd_field  = instr_i[RD_LSB +: RF_AWIDTH];
    assign rs1_field = instr_i[RS1_LSB +: RF_AWIDTH];

    // csrrw skips the read for rd x0, csrrs/csrrc skip the write for rs1 x0
    always_comb begin
        case (id2exe_ctrl_i.csr_op)
            CSR_OP_WRITE: begin
                csr_req.csr_rd_req = |rd_field;
                csr_req.csr_wr_req = 1'b1;
            end
            CSR_OP_SET,
            CSR_OP_CLEAR: begin
                csr_req.csr_rd_req = 1'b1;
                csr_req.csr_wr_req = |rs1_field;
            end
            default: begin
                csr_req.csr_rd_req = 1'b0;
                csr_req.csr_wr_req = 1'b0;
            end
        endcase
    end

    assign csr_req.csr_op   = id2exe_ctrl_i.csr_op;
    assign csr_req.csr_addr = instr_i[CSR_ADDR_LSB +: CSR_AWIDTH];

    // Register operand or zero-extended uimm from the rs1 field
    assign csr_req.csr_wdata = (id2exe_ctrl_i.csr_opr_sel == CSR_OPR_SEL_REG)
                             ? rs1_fwd_i
                             : xlen_t'(rs1_field);

    // CSR ops write rd only when the CSR is read
    assign rd_wr_req_o = (id2exe_ctrl_i.csr_op != CSR_OP_NONE)
                       ? csr_req.csr_rd_req
                       : id2exe_ctrl_i.rd_wr_req;

    assign exe2csr_o = csr_req;

endmodule : csr_req_gen

/* hdl/exe_mem_reg.sv */
`timescale 1ns/10ps

module exe_mem_reg
    import exe_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  exe2lsu_s lsu_d_i,
    input  exe2csr_s csr_d_i,
    output exe2lsu_s exe2lsu_o,
    output exe2csr_s exe2csr_o
);

    exe2lsu_s lsu_q;
    exe2csr_s csr_q;

    // LSU side bundle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // No rd write pending out of reset
            lsu_q <= '0;
        end else begin
            lsu_q <= lsu_d_i;
        end
    end

    // CSR side bundle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // Clears both CSR requests
            csr_q <= '0;
        end else begin
            csr_q <= csr_d_i;
        end
    end

    // No stall, the register loads every cycle
    assign exe2lsu_o = lsu_q;
    assign exe2csr_o = csr_q;

endmodule : exe_mem_reg

/* hdl/exe_stage.sv */
`timescale 1ns/10ps

module exe_stage
    import exe_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  id2exe_ctrl_s id2exe_ctrl_i,
    input  id2exe_data_s id2exe_data_i,
    input  fwd_sel_s     fwd_sel_i,
    input  xlen_t        lsu_fb_data_i,
    input  xlen_t        wrb_fb_data_i,
    output exe2lsu_s     exe2lsu_o,
    output exe2csr_s     exe2csr_o,
    output redirect_s    redirect_o
);

    // Operands after forwarding
    xlen_t      rs1_fwd;
    xlen_t      rs2_fwd;
    xlen_t      alu_opr1;
    xlen_t      alu_opr2;
    xlen_t      cmp_opr2;
    // Comparator and ALU results
    cmp_flags_s cmp_flags;
    logic       branch_taken;
    xlen_t      alu_result;
    // Bundles into the EXE/MEM register
    exe2csr_s   csr_req;
    exe2lsu_s   lsu_req;
    logic       rd_wr_req;
    rf_addr_t   rd_addr;

    operand_fwd operand_fwd_inst (
        .id2exe_ctrl_i (id2exe_ctrl_i),
        .id2exe_data_i (id2exe_data_i),
        .fwd_sel_i     (fwd_sel_i),
        .lsu_fb_data_i (lsu_fb_data_i),
        .wrb_fb_data_i (wrb_fb_data_i),
        .rs1_fwd_o     (rs1_fwd),
        .rs2_fwd_o     (rs2_fwd),
        .alu_opr1_o    (alu_opr1),
        .alu_opr2_o    (alu_opr2),
        .cmp_opr2_o    (cmp_opr2)
    );

    branch_cmp branch_cmp_inst (
        .rs1_fwd_i      (rs1_fwd),
        .cmp_opr2_i     (cmp_opr2),
        .br_op_i        (id2exe_ctrl_i.br_op),
        .cmp_flags_o    (cmp_flags),
        .branch_taken_o (branch_taken)
    );

    int_alu int_alu_inst (
        .alu_op_i     (id2exe_ctrl_i.alu_op),
        .alu_opr1_i   (alu_opr1),
        .alu_opr2_i   (alu_opr2),
        .cmp_flags_i  (cmp_flags),
        .alu_result_o (alu_result)
    );

    csr_req_gen csr_req_gen_inst (
        .id2exe_ctrl_i (id2exe_ctrl_i),
        .instr_i       (id2exe_data_i.instr),
        .rs1_fwd_i     (rs1_fwd),
        .exe2csr_o     (csr_req),
        .rd_wr_req_o   (rd_wr_req)
    );

    // Destination register field
    assign rd_addr = id2exe_data_i.instr[RD_LSB +: RF_AWIDTH];

    // Forwarded rs2 is the store data
    assign lsu_req.alu_result = alu_result;
    assign lsu_req.rs2_data   = rs2_fwd;
    assign lsu_req.rd_addr    = rd_addr;
    assign lsu_req.rd_wr_req  = rd_wr_req;

    exe_mem_reg exe_mem_reg_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .lsu_d_i   (lsu_req),
        .csr_d_i   (csr_req),
        .exe2lsu_o (exe2lsu_o),
        .exe2csr_o (exe2csr_o)
    );

    // Same-cycle redirect for fence.i, jumps and taken branches
    assign redirect_o.new_pc_req = id2exe_ctrl_i.fence_i_req |
                                   id2exe_ctrl_i.jump_req |
                                   (id2exe_ctrl_i.branch_req & branch_taken);
    // fence.i refetches the next instruction and others use the ALU target
    assign redirect_o.pc_new     = id2exe_ctrl_i.fence_i_req ? id2exe_data_i.pc_next : alu_result;

endmodule : exe_stage

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 16;

    // 40 ns clock, low at time zero
    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD;
            clk_o = ~clk_o;
        end
    end

    // Reset spans the first 16 rising edges, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        #(RESET_CYCLES * 2 * HALF_PERIOD);
        rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen

/* verification/exe_stage_asserts.sv */
`timescale 1ns/10ps

module exe_stage_asserts
    import exe_pkg::*;
(
    input logic         clk_i,
    input logic         rst_n_i,
    input id2exe_ctrl_s id2exe_ctrl_i,
    input exe2lsu_s     exe2lsu_i,
    input exe2csr_s     exe2csr_i,
    input redirect_s    redirect_i
);

    // Registered requests come out of reset cleared
    property reset_clears_requests;
        @(posedge clk_i) !rst_n_i |=>
            !(exe2lsu_i.rd_wr_req || exe2csr_i.csr_rd_req || exe2csr_i.csr_wr_req);
    endproperty

    // fence.i must always refetch
    property fence_i_redirects;
        @(posedge clk_i) disable iff (!rst_n_i)
            id2exe_ctrl_i.fence_i_req |-> redirect_i.new_pc_req;
    endproperty

    // A CSR write only comes with a real CSR op
    property csr_write_needs_op;
        @(posedge clk_i) disable iff (!rst_n_i)
            $rose(exe2csr_i.csr_wr_req) |-> (exe2csr_i.csr_op != CSR_OP_NONE);
    endproperty

    reset_clears_requests_a: assert property (reset_clears_requests)
        else $error("EXE/MEM request bits set in the cycle after reset");
    fence_i_redirects_a: assert property (fence_i_redirects)
        else $error("fence.i without a fetch redirect");
    csr_write_needs_op_a: assert property (csr_write_needs_op)
        else $error("CSR write request raised with no CSR op");

endmodule : exe_stage_asserts

/* verification/exe_stage_tb.sv */
`timescale 1ns/10ps

module exe_stage_tb
    import exe_pkg::*;
();

    localparam int          EDGE_POLLS  = 100;
    localparam int          RESET_POLLS = 1000;
    localparam logic [31:0] LFSR_SEED   = 32'd72544;
    // Taps of x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    logic clk;
    logic rst_n;

    // DUT inputs
    id2exe_ctrl_s id2exe_ctrl;
    id2exe_data_s id2exe_data;
    fwd_sel_s     fwd_sel;
    xlen_t        lsu_fb_data;
    xlen_t        wrb_fb_data;
    // DUT outputs
    exe2lsu_s     exe2lsu;
    exe2csr_s     exe2csr;
    redirect_s    redirect;

    // Expected EXE/MEM contents for the instruction issued last
    logic         pend_valid;
    string        pend_name;
    exe2lsu_s     pend_lsu;
    exe2csr_s     pend_csr;
    logic [31:0]  lfsr_state;
    int           fail_count;

    tb_clock_gen clock_gen_inst (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    exe_stage exe_stage_inst (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .id2exe_ctrl_i (id2exe_ctrl),
        .id2exe_data_i (id2exe_data),
        .fwd_sel_i     (fwd_sel),
        .lsu_fb_data_i (lsu_fb_data),
        .wrb_fb_data_i (wrb_fb_data),
        .exe2lsu_o     (exe2lsu),
        .exe2csr_o     (exe2csr),
        .redirect_o    (redirect)
    );

    bind exe_stage exe_stage_asserts exe_stage_asserts_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .id2exe_ctrl_i (id2exe_ctrl_i),
        .exe2lsu_i     (exe2lsu_o),
        .exe2csr_i     (exe2csr_o),
        .redirect_i    (redirect_o)
    );

    // Galois step, shift right and fold the taps in on a one
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic xlen_t rand_word();
        xlen_t w;
        w = '0;
        for (int i = 0; i < XLEN; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[XLEN-2:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic id2exe_data_s rand_data();
        id2exe_data_s d;
        d.instr    = rand_word();
        d.pc       = rand_word() & 32'hffff_fffc;
        d.pc_next  = d.pc + 32'd4;
        d.imm      = rand_word();
        d.rs1_data = rand_word();
        d.rs2_data = rand_word();
        return d;
    endfunction

    // All selects on register, nothing requested
    function automatic id2exe_ctrl_s base_ctrl(input alu_op_e op);
        id2exe_ctrl_s c;
        c        = '0;
        c.alu_op = op;
        return c;
    endfunction

    task automatic stop_on_failure(input string msg);
        fail_count++;
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("** Error %s: expected %0h, actual %0h",
                                      name, expected, actual));
        end
    endtask

    // Poll until clk reaches to_level through a transition
    task automatic wait_edge(input logic to_level, input string what);
        int polls;
        polls = 0;
        while (clk === to_level && polls < EDGE_POLLS) begin
            #1;
            polls++;
        end
        while (clk !== to_level && polls < EDGE_POLLS) begin
            #1;
            polls++;
        end
        if (clk !== to_level) begin
            stop_on_failure({"No ", what, " clock edge seen within the timeout"});
        end
    endtask

    task automatic wait_reset_release();
        int polls;
        polls = 0;
        while (rst_n !== 1'b1 && polls < RESET_POLLS) begin
            #1;
            polls++;
        end
        if (rst_n !== 1'b1) begin
            stop_on_failure("Reset was never released");
        end
    endtask

    // Expected stage outputs from the forwarding, ALU, branch and CSR rules
    task automatic predict(input id2exe_ctrl_s c, input id2exe_data_s d, input fwd_sel_s f,
                           input xlen_t lsu_fb, input xlen_t wrb_fb,
                           output exe2lsu_s lsu, output exe2csr_s csr, output redirect_s rdr);
        xlen_t    rs1;
        xlen_t    rs2;
        xlen_t    a;
        xlen_t    b;
        xlen_t    cb;
        xlen_t    res;
        logic     taken;
        rf_addr_t rs1_f;
        // Youngest producer wins
        rs1 = f.fwd_lsu_rs1 ? lsu_fb : (f.fwd_wrb_rs1 ? wrb_fb : d.rs1_data);
        rs2 = f.fwd_lsu_rs2 ? lsu_fb : (f.fwd_wrb_rs2 ? wrb_fb : d.rs2_data);
        a   = (c.opr1_sel == OPR1_SEL_PC) ? d.pc : rs1;
        b   = (c.opr2_sel == OPR2_SEL_IMM) ? d.imm : rs2;
        cb  = (c.cmp_opr2_sel == CMP_OPR2_SEL_IMM) ? d.imm : rs2;
        case (c.alu_op)
            ALU_OP_ADD:       res = a + b;
            ALU_OP_SUB:       res = a - b;
            ALU_OP_AND:       res = a & b;
            ALU_OP_OR:        res = a | b;
            ALU_OP_XOR:       res = a ^ b;
            ALU_OP_SLL:       res = a << b[4:0];
            ALU_OP_SRL:       res = a >> b[4:0];
            ALU_OP_SRA:       res = $signed(a) >>> b[4:0];
            // slt compares rs1 with the comparator operand
            ALU_OP_SLT:       res = {31'd0, $signed(rs1) < $signed(cb)};
            ALU_OP_SLTU:      res = {31'd0, rs1 < cb};
            ALU_OP_COPY_OPR1: res = a;
            ALU_OP_COPY_OPR2: res = b;
            default:          res = '0;
        endcase
        case (c.br_op)
            BR_OP_EQ:  taken = (rs1 == cb);
            BR_OP_NE:  taken = (rs1 != cb);
            BR_OP_LT:  taken = ($signed(rs1) < $signed(cb));
            BR_OP_LTU: taken = (rs1 < cb);
            BR_OP_GE:  taken = ($signed(rs1) >= $signed(cb));
            BR_OP_GEU: taken = (rs1 >= cb);
            default:   taken = 1'b0;
        endcase
        rdr.new_pc_req = c.fence_i_req | c.jump_req | (c.branch_req & taken);
        rdr.pc_new     = c.fence_i_req ? d.pc_next : res;
        rs1_f          = d.instr[RS1_LSB +: RF_AWIDTH];
        csr.csr_addr   = d.instr[CSR_ADDR_LSB +: CSR_AWIDTH];
        csr.csr_op     = c.csr_op;
        csr.csr_wdata  = (c.csr_opr_sel == CSR_OPR_SEL_IMM) ? {27'd0, rs1_f} : rs1;
        // csrrw reads only for rd != x0, csrrs/csrrc write only for rs1 != x0
        csr.csr_rd_req = (c.csr_op == CSR_OP_SET) || (c.csr_op == CSR_OP_CLEAR) ||
                         ((c.csr_op == CSR_OP_WRITE) && (d.instr[RD_LSB +: RF_AWIDTH] != '0));
        csr.csr_wr_req = (c.csr_op == CSR_OP_WRITE) ||
                         ((c.csr_op != CSR_OP_NONE) && (rs1_f != '0));
        lsu.alu_result = res;
        lsu.rs2_data   = rs2;
        lsu.rd_addr    = d.instr[RD_LSB +: RF_AWIDTH];
        lsu.rd_wr_req  = (c.csr_op != CSR_OP_NONE) ? csr.csr_rd_req : c.rd_wr_req;
    endtask

    // Registered result of the previous instruction, seen after the falling edge
    task automatic check_pending();
        if (pend_valid) begin
            check({pend_name, " lsu"}, 128'(pend_lsu), 128'(exe2lsu));
            check({pend_name, " csr"}, 128'(pend_csr), 128'(exe2csr));
        end
    endtask

    // Drive one instruction, check the one before it and this redirect
    task automatic issue(input string name, input id2exe_ctrl_s c, input id2exe_data_s d,
                         input fwd_sel_s f, input xlen_t lsu_fb, input xlen_t wrb_fb);
        exe2lsu_s  exp_lsu;
        exe2csr_s  exp_csr;
        redirect_s exp_rdr;
        wait_edge(1'b0, "falling");
        check_pending();
        id2exe_ctrl = c;
        id2exe_data = d;
        fwd_sel     = f;
        lsu_fb_data = lsu_fb;
        wrb_fb_data = wrb_fb;
        predict(c, d, f, lsu_fb, wrb_fb, exp_lsu, exp_csr, exp_rdr);
        pend_valid  = 1'b1;
        pend_name   = name;
        pend_lsu    = exp_lsu;
        pend_csr    = exp_csr;
        // Redirect is combinational, inputs have been stable for half a cycle
        wait_edge(1'b1, "rising");
        check({name, " redirect"}, 128'(exp_rdr), 128'(redirect));
    endtask

    task automatic drain();
        wait_edge(1'b0, "falling");
        check_pending();
        pend_valid = 1'b0;
    endtask

    task automatic check_after_reset();
        wait_edge(1'b0, "falling");
        check("reset rd_wr_req", 128'(1'b0), 128'(exe2lsu.rd_wr_req));
        check("reset csr_rd_req", 128'(1'b0), 128'(exe2csr.csr_rd_req));
        check("reset csr_wr_req", 128'(1'b0), 128'(exe2csr.csr_wr_req));
        check("reset lsu bundle", 128'(0), 128'(exe2lsu));
        check("reset csr bundle", 128'(0), 128'(exe2csr));
    endtask

    // Back to back ops keep two instructions in flight
    task automatic alu_ops();
        id2exe_ctrl_s c;
        id2exe_data_s d;
        for (int op = 1; op <= 12; op++) begin
            for (int k = 0; k < 5; k++) begin
                c           = base_ctrl(alu_op_e'(op[3:0]));
                c.rd_wr_req = k[0];
                d           = rand_data();
                if (k == 2) begin
                    // Minimum value, shift by 31
                    d.rs1_data = 32'h8000_0000;
                    d.rs2_data = 32'd31;
                end else if (k == 3) begin
                    d.rs1_data = 32'hffff_ffff;
                    d.rs2_data = 32'h8000_0000;
                end else if (k == 4) begin
                    // All ones immediate on both operand 2 paths
                    c.opr2_sel     = OPR2_SEL_IMM;
                    c.cmp_opr2_sel = CMP_OPR2_SEL_IMM;
                    d.imm          = 32'hffff_ffff;
                end
                issue($sformatf("alu op %0d case %0d", op, k), c, d, '0, '0, '0);
            end
        end
    endtask

    task automatic forwarding_priority();
        id2exe_ctrl_s c;
        id2exe_data_s d;
        c           = base_ctrl(ALU_OP_ADD);
        c.rd_wr_req = 1'b1;
        d           = rand_data();
        // Distinct magnitudes so every source shows in the sum
        d.rs1_data  = 32'h0000_0030;
        d.rs2_data  = 32'h0000_4000;
        for (int f = 0; f < 16; f++) begin
            issue($sformatf("fwd sel %b", f[3:0]), c, d, fwd_sel_s'(f[3:0]),
                  32'h1000_0000, 32'h0200_0000);
        end
    endtask

    task automatic branch_and_jump();
        xlen_t        pair_a [8];
        xlen_t        pair_b [8];
        id2exe_ctrl_s c;
        id2exe_data_s d;
        xlen_t        w;
        // Signed and unsigned boundary pairs
        pair_a = '{32'h0, 32'h1, 32'h0, 32'h7fff_ffff, 32'h8000_0000,
                   32'hffff_ffff, 32'h0, 32'h8000_0000};
        pair_b = '{32'h0, 32'h0, 32'h1, 32'h8000_0000, 32'h7fff_ffff,
                   32'h0, 32'hffff_ffff, 32'h8000_0000};
        for (int br = 1; br <= 6; br++) begin
            for (int p = 0; p < 8; p++) begin
                c            = base_ctrl(ALU_OP_ADD);
                c.br_op      = br_op_e'(br[2:0]);
                c.branch_req = 1'b1;
                c.opr1_sel   = OPR1_SEL_PC;
                c.opr2_sel   = OPR2_SEL_IMM;
                d            = rand_data();
                w            = rand_word();
                d.imm        = {{20{w[11]}}, w[11:1], 1'b0};
                d.rs1_data   = pair_a[p];
                d.rs2_data   = pair_b[p];
                issue($sformatf("branch op %0d pair %0d", br, p), c, d, '0, '0, '0);
            end
        end
        // Condition true but no branch requested
        c          = base_ctrl(ALU_OP_ADD);
        c.br_op    = BR_OP_EQ;
        d          = rand_data();
        d.rs2_data = d.rs1_data;
        issue("branch not requested", c, d, '0, '0, '0);
        c           = base_ctrl(ALU_OP_ADD);
        c.jump_req  = 1'b1;
        c.rd_wr_req = 1'b1;
        c.opr1_sel  = OPR1_SEL_PC;
        c.opr2_sel  = OPR2_SEL_IMM;
        issue("jump", c, rand_data(), '0, '0, '0);
        c             = base_ctrl(ALU_OP_NONE);
        c.fence_i_req = 1'b1;
        issue("fence.i", c, rand_data(), '0, '0, '0);
    endtask

    task automatic csr_requests();
        id2exe_ctrl_s c;
        id2exe_data_s d;
        fwd_sel_s     f;
        rf_addr_t     rd;
        rf_addr_t     rs1f;
        for (int op = 1; op <= 3; op++) begin
            for (int k = 0; k < 8; k++) begin
                rd            = k[0] ? 5'd5 : 5'd0;
                rs1f          = k[1] ? 5'd9 : 5'd0;
                c             = base_ctrl(ALU_OP_NONE);
                c.csr_op      = csr_op_e'(op[1:0]);
                c.csr_opr_sel = csr_opr_sel_e'(k[2]);
                c.rd_wr_req   = 1'b1;
                d             = rand_data();
                d.instr       = {d.instr[31:20], rs1f, 3'b001, rd, 7'b1110011};
                // rs1 comes from the LSU stage when its field is nonzero
                f             = '0;
                f.fwd_lsu_rs1 = k[1];
                issue($sformatf("csr op %0d rd %0d rs1 %0d sel %0d", op, rd, rs1f, k[2]),
                      c, d, f, rand_word(), rand_word());
            end
        end
    endtask

    initial begin
        id2exe_ctrl = '0;
        id2exe_data = '0;
        fwd_sel     = '0;
        lsu_fb_data = '0;
        wrb_fb_data = '0;
        pend_valid  = 1'b0;
        pend_name   = "";
        pend_lsu    = '0;
        pend_csr    = '0;
        fail_count  = 0;
        lfsr_state  = LFSR_SEED;
        wait_reset_release();
        check_after_reset();
        alu_ops();
        forwarding_priority();
        branch_and_jump();
        csr_requests();
        drain();
        if (fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule : exe_stage_tb

/* exe_stage.f */
common/exe_pkg.sv
hdl/operand_fwd.sv
alu/branch_cmp.sv
alu/int_alu.sv
hdl/csr_req_gen.sv
hdl/exe_mem_reg.sv
hdl/exe_stage.sv
verification/tb_clock_gen.sv
verification/exe_stage_asserts.sv
verification/exe_stage_tb.sv

/* Makefile */
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exe_stage_tb
FILELIST  ?= exe_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The run passes only if the pass line appears in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
